/* src/vec_pkg.sv */
package vec_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Lane count, must stay a power of two
  localparam int unsigned NrLanes      = 4;
  localparam int unsigned LaneIdxWidth = $clog2(NrLanes);

  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned RegIdxWidth  = $clog2(NrVRegs);

  // Request and response queues share one depth
  localparam int unsigned FifoDepth    = 4;
  localparam int unsigned FifoPtrWidth = $clog2(FifoDepth);
  localparam int unsigned FifoCntWidth = $clog2(FifoDepth + 1);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [ElemWidth-1:0]    elem_t;
  typedef logic [RegIdxWidth-1:0]  reg_idx_t;
  typedef logic [LaneIdxWidth-1:0] lane_idx_t;

  // Code 7 is left free and decodes as illegal
  typedef enum logic [2:0] {
    OP_VADD   = 3'd0,
    OP_VSUB   = 3'd1,
    OP_VAND   = 3'd2,
    OP_VXOR   = 3'd3,
    OP_VMV_VX = 3'd4,
    OP_VID    = 3'd5,
    OP_VEXT   = 3'd6
  } vec_op_e;

  // Host instruction
  typedef struct packed {
    vec_op_e  op;
    reg_idx_t vd;
    reg_idx_t vs1;
    reg_idx_t vs2;
    elem_t    scalar;
  } vec_insn_t;

  // Host response
  typedef struct packed {
    elem_t data;
    logic  illegal;
  } vec_resp_t;

  // Issue word seen by every lane
  typedef struct packed {
    vec_op_e  op;
    reg_idx_t vd;
    reg_idx_t vs1;
    reg_idx_t vs2;
  } lane_req_t;

  // One stage of the lane-to-lane broadcast chain
  typedef struct packed {
    logic  valid;
    logic  last;
    elem_t data;
  } bc_t;

endpackage

/* src/vec_fifo.sv */
`timescale 1ns/1ps

module vec_fifo import vec_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // Write side
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  // Read side
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  payload_t [FifoDepth-1:0] mem_q;

  logic [FifoPtrWidth-1:0] wr_ptr_q;
  logic [FifoPtrWidth-1:0] rd_ptr_q;
  logic [FifoCntWidth-1:0] cnt_q;

  logic push;
  logic pop;

  assign in_ready_o  = (cnt_q != FifoCntWidth'(FifoDepth));
  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == FifoPtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FifoPtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the level
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

/* src/vec_vrf.sv */
`timescale 1ns/1ps

module vec_vrf import vec_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // Read ports
  input  reg_idx_t raddr_a_i,
  input  reg_idx_t raddr_b_i,
  output elem_t    rdata_a_o,
  output elem_t    rdata_b_o,
  // Write port
  input  logic     we_i,
  input  reg_idx_t waddr_i,
  input  elem_t    wdata_i
);

  // One element of each vector register
  elem_t [NrVRegs-1:0] regs_q;

  // Combinational reads
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

/* src/vec_lane.sv */
`timescale 1ns/1ps

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Issue from the dispatcher
  input  logic      issue_valid_i,
  input  lane_req_t issue_req_i,
  // Broadcast chain
  input  bc_t       bc_i,
  output bc_t       bc_o,
  // Back to the dispatcher
  output elem_t     operand_o,
  output logic      done_o
);

  elem_t    rdata_a;
  elem_t    rdata_b;
  elem_t    alu_res;
  logic     alu_we;
  logic     bc_we;
  logic     wr_en;
  reg_idx_t waddr;
  elem_t    wdata;

  logic     bc_pending_q;
  reg_idx_t bc_vd_q;
  bc_t      bc_q;
  logic     done_q;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_res = '0;
    alu_we  = 1'b0;
    if (issue_valid_i) begin
      case (issue_req_i.op)
        OP_VADD: begin
          alu_res = rdata_a + rdata_b;
          alu_we  = 1'b1;
        end
        OP_VSUB: begin
          alu_res = rdata_a - rdata_b;
          alu_we  = 1'b1;
        end
        OP_VAND: begin
          alu_res = rdata_a & rdata_b;
          alu_we  = 1'b1;
        end
        OP_VXOR: begin
          alu_res = rdata_a ^ rdata_b;
          alu_we  = 1'b1;
        end
        OP_VID: begin
          alu_res = elem_t'(LaneId);
          alu_we  = 1'b1;
        end
        // Broadcast writes later, extract only reads
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Write-back and broadcast stage
  ////////////////////////////////////////////////////////////

  assign bc_we = bc_pending_q & bc_i.valid;
  assign wr_en = alu_we | bc_we;
  assign waddr = bc_we ? bc_vd_q : issue_req_i.vd;
  assign wdata = bc_we ? bc_i.data : alu_res;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bc_pending_q <= 1'b0;
      bc_q         <= '0;
      done_q       <= 1'b0;
    end else begin
      if (issue_valid_i && issue_req_i.op == OP_VMV_VX) begin
        bc_pending_q <= 1'b1;
      end else if (bc_we && bc_i.last) begin
        bc_pending_q <= 1'b0;
      end
      // Pass the scalar on to the next lane
      bc_q   <= bc_i;
      done_q <= wr_en;
    end
  end

  // Destination held until the scalar arrives
  always_ff @(posedge clk_i) begin
    if (issue_valid_i && issue_req_i.op == OP_VMV_VX) begin
      bc_vd_q <= issue_req_i.vd;
    end
  end

  assign bc_o      = bc_q;
  assign done_o    = done_q;
  assign operand_o = rdata_b;

  vec_vrf i_vrf (
    .clk_i    (clk_i          ),
    .reset_i  (reset_i        ),
    .raddr_a_i(issue_req_i.vs1),
    .raddr_b_i(issue_req_i.vs2),
    .rdata_a_o(rdata_a        ),
    .rdata_b_o(rdata_b        ),
    .we_i     (wr_en          ),
    .waddr_i  (waddr          ),
    .wdata_i  (wdata          )
  );

endmodule

/* src/vec_dispatcher.sv */
`timescale 1ns/1ps

module vec_dispatcher import vec_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // From the request queue
  input  logic                    insn_valid_i,
  input  vec_insn_t               insn_i,
  output logic                    insn_ready_o,
  // To the response queue
  output logic                    resp_valid_o,
  output vec_resp_t               resp_o,
  input  logic                    resp_ready_i,
  // To the lanes
  output logic                    issue_valid_o,
  output lane_req_t               issue_req_o,
  output bc_t                     bc_head_o,
  // From the lanes
  input  elem_t [NrLanes-1:0]     lane_operand_i,
  input  logic                    lane_done_i
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_DONE,
    RESPOND
  } state_e;

  state_e    state_q, state_d;
  vec_resp_t resp_q, resp_d;
  bc_t       bc_head_q;

  logic      insn_fire;
  logic      insn_legal;
  logic      bc_issue;
  lane_idx_t ext_lane;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // Only start when the response queue has room for the answer
  assign insn_ready_o = (state_q == IDLE) & resp_ready_i;
  assign insn_fire    = insn_valid_i & insn_ready_o;

  always_comb begin
    case (insn_i.op)
      OP_VADD, OP_VSUB, OP_VAND, OP_VXOR,
      OP_VMV_VX, OP_VID, OP_VEXT: insn_legal = 1'b1;
      default:                    insn_legal = 1'b0;
    endcase
  end

  // Extract picks its lane from the low scalar bits
  assign ext_lane = insn_i.scalar[LaneIdxWidth-1:0];

  // Lanes only look at this when issue_valid_o is high
  assign issue_req_o = '{
    op:  insn_i.op,
    vd:  insn_i.vd,
    vs1: insn_i.vs1,
    vs2: insn_i.vs2
  };

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    resp_d        = resp_q;
    issue_valid_o = 1'b0;
    bc_issue      = 1'b0;

    case (state_q)
      IDLE: begin
        if (insn_fire) begin
          if (!insn_legal) begin
            resp_d  = '{data: '0, illegal: 1'b1};
            state_d = RESPOND;
          end else if (insn_i.op == OP_VEXT) begin
            // Read-only, the lane operand is already valid
            issue_valid_o = 1'b1;
            resp_d        = '{data: lane_operand_i[ext_lane], illegal: 1'b0};
            state_d       = RESPOND;
          end else begin
            issue_valid_o = 1'b1;
            bc_issue      = (insn_i.op == OP_VMV_VX);
            resp_d        = '{data: '0, illegal: 1'b0};
            state_d       = WAIT_DONE;
          end
        end
      end
      WAIT_DONE: begin
        // Last lane reports the final write
        if (lane_done_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (resp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign resp_valid_o = (state_q == RESPOND);
  assign resp_o       = resp_q;
  assign bc_head_o    = bc_head_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      bc_head_q <= '0;
    end else begin
      state_q   <= state_d;
      // Head of the chain, one word per broadcast
      bc_head_q <= '{valid: bc_issue, last: 1'b1, data: insn_i.scalar};
    end
  end

  always_ff @(posedge clk_i) begin
    resp_q <= resp_d;
  end

endmodule

/* src/vec_top.sv */
`timescale 1ns/1ps

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Host request channel
  input  logic      req_valid_i,
  input  vec_insn_t req_i,
  output logic      req_ready_o,
  // Host response channel
  output logic      resp_valid_o,
  output vec_resp_t resp_o,
  input  logic      resp_ready_i
);

  ////////////////////////////////////////////////////////////
  // Queues
  ////////////////////////////////////////////////////////////

  logic      insn_valid;
  vec_insn_t insn;
  logic      insn_ready;
  logic      disp_resp_valid;
  vec_resp_t disp_resp;
  logic      disp_resp_ready;

  vec_fifo #(.payload_t(vec_insn_t)) i_req_fifo (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .in_valid_i (req_valid_i),
    .in_data_i  (req_i      ),
    .in_ready_o (req_ready_o),
    .out_valid_o(insn_valid ),
    .out_data_o (insn       ),
    .out_ready_i(insn_ready )
  );

  vec_fifo #(.payload_t(vec_resp_t)) i_resp_fifo (
    .clk_i      (clk_i          ),
    .reset_i    (reset_i        ),
    .in_valid_i (disp_resp_valid),
    .in_data_i  (disp_resp      ),
    .in_ready_o (disp_resp_ready),
    .out_valid_o(resp_valid_o   ),
    .out_data_o (resp_o         ),
    .out_ready_i(resp_ready_i   )
  );

  ////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////

  logic                issue_valid;
  lane_req_t           issue_req;
  bc_t                 bc_head;
  elem_t [NrLanes-1:0] lane_operand;
  logic  [NrLanes-1:0] lane_done;

  vec_dispatcher i_dispatcher (
    .clk_i         (clk_i               ),
    .reset_i       (reset_i             ),
    .insn_valid_i  (insn_valid          ),
    .insn_i        (insn                ),
    .insn_ready_o  (insn_ready          ),
    .resp_valid_o  (disp_resp_valid     ),
    .resp_o        (disp_resp           ),
    .resp_ready_i  (disp_resp_ready     ),
    .issue_valid_o (issue_valid         ),
    .issue_req_o   (issue_req           ),
    .bc_head_o     (bc_head             ),
    .lane_operand_i(lane_operand        ),
    .lane_done_i   (lane_done[NrLanes-1])
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  bc_t [NrLanes-1:0] bc_in;
  bc_t [NrLanes-1:0] bc_out;

  for (genvar k = 0; k < NrLanes; k++) begin : gen_lanes
    vec_lane #(.LaneId(k)) i_lane (
      .clk_i        (clk_i          ),
      .reset_i      (reset_i        ),
      .issue_valid_i(issue_valid    ),
      .issue_req_i  (issue_req      ),
      .bc_i         (bc_in[k]       ),
      .bc_o         (bc_out[k]      ),
      .operand_o    (lane_operand[k]),
      .done_o       (lane_done[k]   )
    );

    // Lane 0 takes the head, the others the previous stage
    if (k == 0) begin : gen_bc_head
      assign bc_in[k] = bc_head;
    end else begin : gen_bc_link
      assign bc_in[k] = bc_out[k-1];
    end
  end

endmodule

/* test/tb_vec_top.sv */
`timescale 1ns/1ps

module tb_vec_top import vec_pkg::*; ();

  localparam int unsigned ClkPeriod     = 10;
  localparam int unsigned TimeoutCycles = 200;
  localparam int unsigned FullWait      = 20;
  localparam int unsigned MaxFill       = 32;
  localparam elem_t       Seed          = 32'd67640;

  logic      clk_i;
  logic      reset_i;
  logic      req_valid_i;
  vec_insn_t req_i;
  logic      req_ready_o;
  logic      resp_valid_o;
  vec_resp_t resp_o;
  logic      resp_ready_i;

  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  elem_t       rng;
  elem_t       s;

  vec_top UUT (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .req_valid_i (req_valid_i ),
    .req_i       (req_i       ),
    .req_ready_o (req_ready_o ),
    .resp_valid_o(resp_valid_o),
    .resp_o      (resp_o      ),
    .resp_ready_i(resp_ready_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic elem_t xorshift32(input elem_t x);
    elem_t y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Raw opcode bits so that code 7 can be sent too
  function automatic vec_insn_t make_insn(input logic [2:0] op, input reg_idx_t vd,
                                          input reg_idx_t vs1, input reg_idx_t vs2,
                                          input elem_t scalar);
    return {op, vd, vs1, vs2, scalar};
  endfunction

  function automatic vec_resp_t resp_of(input elem_t data, input logic illegal);
    vec_resp_t r;
    r.data    = data;
    r.illegal = illegal;
    return r;
  endfunction

  // Destinations v4 to v7 hold these four results
  function automatic vec_op_e alu_op(input int unsigned k);
    case (k)
      0:       return OP_VADD;
      1:       return OP_VSUB;
      2:       return OP_VAND;
      default: return OP_VXOR;
    endcase
  endfunction

  function automatic elem_t alu_expect(input vec_op_e op, input elem_t a, input elem_t b);
    case (op)
      OP_VADD: return a + b;
      OP_VSUB: return a - b;
      OP_VAND: return a & b;
      OP_VXOR: return a ^ b;
      default: return '0;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_resp(input vec_resp_t exp, input vec_resp_t act, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s expected data=%h illegal=%b, got data=%h illegal=%b",
               $time, name, exp.data, exp.illegal, act.data, act.illegal);
    end
  endtask

  task automatic check_elem(input elem_t exp, input elem_t act, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input logic exp, input logic act, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Host channel
  ////////////////////////////////////////////////////////////

  // Ready is sampled mid-cycle and the transfer happens on the next edge
  task automatic send_insn(input vec_insn_t insn);
    int unsigned waited;
    bit          accepted;
    waited      = 0;
    accepted    = 1'b0;
    req_i       = insn;
    req_valid_i = 1'b1;
    while (!accepted && waited < TimeoutCycles) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      next_cycle();
      waited++;
    end
    req_valid_i = 1'b0;
    if (!accepted) begin
      errors++;
      $display("Timeout at %0t ns: request was not accepted in %0d cycles",
               $time, TimeoutCycles);
    end
  endtask

  task automatic get_resp(output vec_resp_t r);
    int unsigned waited;
    bit          got;
    waited       = 0;
    got          = 1'b0;
    r            = '0;
    resp_ready_i = 1'b1;
    while (!got && waited < TimeoutCycles) begin
      @(negedge clk_i);
      if (resp_valid_o) begin
        got = 1'b1;
        r   = resp_o;
      end
      next_cycle();
      waited++;
    end
    resp_ready_i = 1'b0;
    if (!got) begin
      errors++;
      $display("Timeout at %0t ns: no response arrived in %0d cycles", $time, TimeoutCycles);
    end
  endtask

  // Looks for a free slot without raising valid
  task automatic wait_ready(input int unsigned limit, output bit ready);
    int unsigned waited;
    waited = 0;
    ready  = 1'b0;
    while (!ready && waited < limit) begin
      @(negedge clk_i);
      ready = req_ready_o;
      next_cycle();
      waited++;
    end
  endtask

  task automatic execute_insn(input vec_insn_t insn, output vec_resp_t r);
    send_insn(insn);
    get_resp(r);
  endtask

  // Upper scalar bits are random and only the low bits pick the lane
  task automatic extract_lane(input reg_idx_t vreg, input int unsigned lane,
                              output vec_resp_t r);
    elem_t scalar;
    rng    = xorshift32(rng);
    scalar = (rng & ~elem_t'(NrLanes - 1)) | elem_t'(lane);
    execute_insn(make_insn(OP_VEXT, '0, '0, vreg, scalar), r);
  endtask

  task automatic end_test(input string name, input int unsigned errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("%s passed", name);
    end else begin
      $display("%s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int unsigned errs;
    errs = errors;
    @(negedge clk_i);
    check_bit(1'b0, resp_valid_o, "resp_valid_o");
    check_bit(1'b1, req_ready_o, "req_ready_o");
    next_cycle();
    end_test("reset state", errs);
  endtask

  task automatic test_broadcast();
    int unsigned errs;
    vec_resp_t   r;
    errs = errors;
    execute_insn(make_insn(OP_VMV_VX, 3'd1, '0, '0, s), r);
    check_bit(1'b0, r.illegal, "resp_o.illegal");
    for (int unsigned i = 0; i < NrLanes; i++) begin
      extract_lane(3'd1, i, r);
      check_resp(resp_of(s, 1'b0), r, "resp_o");
    end
    end_test("scalar broadcast", errs);
  endtask

  task automatic test_alu();
    int unsigned errs;
    vec_resp_t   r;
    errs = errors;
    execute_insn(make_insn(OP_VID, 3'd2, '0, '0, '0), r);
    check_bit(1'b0, r.illegal, "resp_o.illegal");
    execute_insn(make_insn(OP_VMV_VX, 3'd3, '0, '0, s), r);
    check_bit(1'b0, r.illegal, "resp_o.illegal");
    // v4 to v7 take v2 op v3
    for (int unsigned k = 0; k < 4; k++) begin
      execute_insn(make_insn(alu_op(k), reg_idx_t'(4 + k), 3'd2, 3'd3, '0), r);
      check_bit(1'b0, r.illegal, "resp_o.illegal");
    end
    for (int unsigned k = 0; k < 4; k++) begin
      for (int unsigned i = 0; i < NrLanes; i++) begin
        extract_lane(reg_idx_t'(4 + k), i, r);
        check_elem(alu_expect(alu_op(k), elem_t'(i), s), r.data, "resp_o.data");
        check_bit(1'b0, r.illegal, "resp_o.illegal");
      end
    end
    end_test("index and alu ops", errs);
  endtask

  task automatic test_illegal();
    int unsigned errs;
    vec_resp_t   r;
    errs = errors;
    // A scalar unlike s shows up if the opcode is ever executed
    execute_insn(make_insn(3'd7, 3'd1, '0, '0, ~s), r);
    check_resp(resp_of('0, 1'b1), r, "resp_o");
    // v1 must be untouched
    for (int unsigned i = 0; i < NrLanes; i++) begin
      extract_lane(3'd1, i, r);
      check_resp(resp_of(s, 1'b0), r, "resp_o");
    end
    end_test("illegal opcode", errs);
  endtask

  task automatic test_backpressure();
    int unsigned errs;
    int unsigned n;
    int unsigned sel;
    int unsigned lane;
    bit          ready;
    bit          chk;
    vec_insn_t   insn;
    vec_resp_t   r;
    vec_resp_t   exp;
    vec_resp_t   exp_q[$];
    bit          data_q[$];
    errs = errors;
    n    = 0;
    resp_ready_i = 1'b0;
    wait_ready(FullWait, ready);
    // Extract, illegal and add in rotation
    while (ready && n < MaxFill) begin
      rng  = xorshift32(rng);
      lane = rng % NrLanes;
      case (n % 3)
        0: begin
          sel  = (n / 3) % 4;
          insn = make_insn(OP_VEXT, '0, '0, reg_idx_t'(4 + sel), rng);
          exp_q.push_back(resp_of(alu_expect(alu_op(sel), elem_t'(lane), s), 1'b0));
          data_q.push_back(1'b1);
        end
        1: begin
          insn = make_insn(3'd7, 3'd1, '0, '0, rng);
          exp_q.push_back(resp_of('0, 1'b1));
          data_q.push_back(1'b1);
        end
        default: begin
          insn = make_insn(OP_VADD, '0, 3'd2, 3'd3, '0);
          exp_q.push_back(resp_of('0, 1'b0));
          data_q.push_back(1'b0);
        end
      endcase
      send_insn(insn);
      n++;
      wait_ready(FullWait, ready);
    end
    $display("%0d requests accepted with responses held", n);
    if (n == 0 || n >= MaxFill) begin
      errors++;
      $display("Request channel never stalled while responses were held");
    end
    while (exp_q.size() > 0) begin
      get_resp(r);
      exp = exp_q.pop_front();
      chk = data_q.pop_front();
      if (chk) begin
        check_resp(exp, r, "resp_o");
      end else begin
        check_bit(exp.illegal, r.illegal, "resp_o.illegal");
      end
    end
    // Nothing beyond the accepted count
    @(negedge clk_i);
    check_bit(1'b0, resp_valid_o, "resp_valid_o");
    next_cycle();
    end_test("back-pressure", errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    rng          = Seed;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    rng = xorshift32(rng);
    s   = rng;

    test_reset();
    test_broadcast();
    test_alu();
    test_illegal();
    test_backpressure();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
src/vec_pkg.sv
src/vec_fifo.sv
src/vec_vrf.sv
src/vec_lane.sv
src/vec_dispatcher.sv
src/vec_top.sv
test/tb_vec_top.sv

/* Makefile */
TOP := tb_vec_top

.PHONY: all lint clean

# Build, run, then decide pass or fail from the log
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

obj_dir/V$(TOP): build.f $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary --top-module $(TOP) -f build.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir sim.log
